// ==== verilog/debug_pkg.sv ====
package debug_pkg;

    localparam int BYTE_W      = 8;
    localparam int REG_W       = 32;
    localparam int NUM_REGS    = 32;
    localparam int IMEM_ADDR_W = 6;
    localparam int OVERSAMPLE  = 16;     // Ticks per serial bit

    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [REG_W-1:0]       word_t;
    typedef logic [IMEM_ADDR_W-1:0] addr_t;

    localparam byte_t CMD_DUMP_REGS    = 8'h01;
    localparam byte_t CMD_DUMP_IF_ID   = 8'h02;
    localparam byte_t CMD_LOAD_PROGRAM = 8'h07;
    localparam byte_t CMD_MODE_CONT    = 8'h08;
    localparam byte_t CMD_MODE_STEP    = 8'h09;
    localparam byte_t CMD_STEP         = 8'h0A;
    localparam byte_t CMD_READ_MEM     = 8'h0B;

    localparam byte_t ACK_BYTE = 8'h52;  // ASCII R

    // Ack carries no payload, only the trailing ACK_BYTE
    typedef enum logic [1:0] {SRC_REGS, SRC_IF_ID, SRC_MEM, SRC_ACK} dump_src_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_COUNT,
        ST_LOAD_BYTES,
        ST_READ_ADDR,
        ST_MEM_WAIT,
        ST_DUMP_BUSY
    } ctrl_state_t;

endpackage

// ==== verilog/uart_tx_if.sv ====
`timescale 1ns/1ps

interface uart_tx_if import debug_pkg::*; ();

    logic  tx_start;    // One-cycle request, only while not busy
    byte_t tx_byte;     // Held by the serializer until tx_done
    logic  tx_busy;
    logic  tx_done;     // Pulse at end of stop bit

    modport serializer (
        output tx_start, tx_byte,
        input  tx_busy, tx_done
    );

    modport transmitter (
        input  tx_start, tx_byte,
        output tx_busy, tx_done
    );

endinterface

// ==== verilog/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 326
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == CNT_W'(CLKS_PER_TICK - 1)) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

// ==== verilog/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver import debug_pkg::*; (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_tick,
    input  logic  i_rx,
    output byte_t o_byte,
    output logic  o_valid
);

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(BYTE_W);
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t         state;
    logic [1:0]        rx_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    byte_t             shift_q;
    logic              mid;
    logic              bit_end;

    assign mid     = i_tick && (tick_cnt == MID_TICK);
    assign bit_end = i_tick && (tick_cnt == LAST_TICK);
    assign o_byte  = shift_q;    // Stable while o_valid is high

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_sync  <= 2'b11;
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            if (i_tick)
                tick_cnt <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (mid) begin    // Recheck start bit at its middle
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(BYTE_W - 1))
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        o_valid  <= rx_sync[1];    // Framing error drops the byte
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end)
            shift_q <= {rx_sync[1], shift_q[BYTE_W-1:1]};    // LSB arrives first
    end

endmodule

// ==== verilog/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter import debug_pkg::*; (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_tick,
    uart_tx_if.transmitter tx_if,
    output logic o_tx
);

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(BYTE_W);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);

    typedef enum logic [2:0] {TX_IDLE, TX_SYNC, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    byte_t             shift_q;
    logic              bit_end;

    assign bit_end       = i_tick && (tick_cnt == LAST_TICK);
    assign tx_if.tx_busy = (state != TX_IDLE);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state         <= TX_IDLE;
            tick_cnt      <= '0;
            bit_cnt       <= '0;
            o_tx          <= 1'b1;
            tx_if.tx_done <= 1'b0;
        end else begin
            tx_if.tx_done <= 1'b0;
            if (i_tick && state != TX_IDLE)
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (tx_if.tx_start)
                        state <= TX_SYNC;
                end
                TX_SYNC: begin    // Align the start bit to the tick grid
                    tick_cnt <= '0;
                    if (i_tick) begin
                        o_tx  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_tx    <= shift_q[0];
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
                            o_tx  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            o_tx    <= shift_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        tx_if.tx_done <= 1'b1;
                        state         <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && tx_if.tx_start)
            shift_q <= tx_if.tx_byte;
        else if (bit_end && (state == TX_START || state == TX_DATA))
            shift_q <= shift_q >> 1;
    end

endmodule

// ==== verilog/dump_serializer.sv ====
`timescale 1ns/1ps

module dump_serializer import debug_pkg::*; #(
    parameter int NUM_REGS = debug_pkg::NUM_REGS
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_dump_req,
    input  dump_src_t                 i_dump_src,
    input  logic [NUM_REGS*REG_W-1:0] i_registers,
    input  word_t                     i_if_id,
    input  word_t                     i_mem_data,
    uart_tx_if.serializer             tx_if,
    output logic                      o_dump_done
);

    localparam int SNAP_W     = NUM_REGS * REG_W;
    localparam int REG_BYTES  = SNAP_W / BYTE_W;
    localparam int WORD_BYTES = REG_W / BYTE_W;
    localparam int CNT_W      = $clog2(REG_BYTES + 1);

    typedef enum logic [1:0] {SER_IDLE, SER_LOAD, SER_WAIT} ser_state_t;

    ser_state_t        state;
    logic [CNT_W-1:0]  left_q;     // Payload bytes not yet sent
    logic [CNT_W-1:0]  req_len;
    logic [SNAP_W-1:0] snap_q;

    always_comb begin
        case (i_dump_src)
            SRC_REGS:  req_len = CNT_W'(REG_BYTES);
            SRC_IF_ID: req_len = CNT_W'(WORD_BYTES);
            SRC_MEM:   req_len = CNT_W'(WORD_BYTES);
            default:   req_len = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state          <= SER_IDLE;
            left_q         <= '0;
            tx_if.tx_start <= 1'b0;
            o_dump_done    <= 1'b0;
        end else begin
            tx_if.tx_start <= 1'b0;
            o_dump_done    <= 1'b0;
            case (state)
                SER_IDLE: begin
                    if (i_dump_req) begin
                        left_q <= req_len;
                        state  <= SER_LOAD;
                    end
                end
                SER_LOAD: begin
                    if (!tx_if.tx_busy) begin
                        tx_if.tx_start <= 1'b1;
                        state          <= SER_WAIT;
                    end
                end
                SER_WAIT: begin
                    if (tx_if.tx_done) begin
                        if (left_q == '0) begin    // Ack byte has gone out
                            o_dump_done <= 1'b1;
                            state       <= SER_IDLE;
                        end else begin
                            left_q <= left_q - 1'b1;
                            state  <= SER_LOAD;
                        end
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SER_IDLE && i_dump_req) begin
            case (i_dump_src)
                SRC_REGS:  snap_q <= i_registers;
                SRC_IF_ID: snap_q <= SNAP_W'(i_if_id);
                SRC_MEM:   snap_q <= SNAP_W'(i_mem_data);
                default:   snap_q <= '0;
            endcase
        end else if (state == SER_WAIT && tx_if.tx_done) begin
            snap_q <= snap_q >> BYTE_W;
        end
        if (state == SER_LOAD && !tx_if.tx_busy)
            tx_if.tx_byte <= (left_q == '0) ? ACK_BYTE : snap_q[BYTE_W-1:0];
    end

endmodule

// ==== verilog/debug_controller.sv ====
`timescale 1ns/1ps

module debug_controller import debug_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  byte_t     i_rx_byte,
    input  logic      i_rx_valid,
    input  logic      i_dump_done,
    output logic      o_dump_req,
    output dump_src_t o_dump_src,
    output logic      o_cpu_en,
    output logic      o_mode_step,
    output logic      o_imem_we,
    output addr_t     o_imem_addr,
    output word_t     o_imem_data,
    output addr_t     o_mem_addr
);

    localparam int IDX_W = $clog2(REG_W / BYTE_W);

    ctrl_state_t      state;
    byte_t            word_total;    // Count byte of the load command
    byte_t            word_cnt;
    logic [IDX_W-1:0] byte_idx;
    logic             mem_wait_q;
    logic             step_q;
    word_t            word_buf;
    word_t            next_word;
    logic             loading;

    assign next_word = {i_rx_byte, word_buf[REG_W-1:BYTE_W]};
    assign loading   = (state == ST_LOAD_COUNT) || (state == ST_LOAD_BYTES);
    assign o_cpu_en  = o_mode_step ? step_q : !loading;    // CPU held while loading

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state       <= ST_IDLE;
            o_mode_step <= 1'b1;
            step_q      <= 1'b0;
            o_imem_we   <= 1'b0;
            o_dump_req  <= 1'b0;
            o_dump_src  <= SRC_REGS;
            word_total  <= '0;
            word_cnt    <= '0;
            byte_idx    <= '0;
            mem_wait_q  <= 1'b0;
        end else begin
            step_q     <= 1'b0;
            o_imem_we  <= 1'b0;
            o_dump_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_valid) begin
                        case (i_rx_byte)
                            CMD_DUMP_REGS: begin
                                o_dump_req <= 1'b1;
                                o_dump_src <= SRC_REGS;
                                state      <= ST_DUMP_BUSY;
                            end
                            CMD_DUMP_IF_ID: begin
                                o_dump_req <= 1'b1;
                                o_dump_src <= SRC_IF_ID;
                                state      <= ST_DUMP_BUSY;
                            end
                            CMD_LOAD_PROGRAM: state <= ST_LOAD_COUNT;
                            CMD_MODE_CONT:    o_mode_step <= 1'b0;
                            CMD_MODE_STEP:    o_mode_step <= 1'b1;
                            CMD_STEP:         step_q <= o_mode_step;
                            CMD_READ_MEM:     state <= ST_READ_ADDR;
                            default:          state <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD_COUNT: begin
                    if (i_rx_valid) begin
                        word_total <= i_rx_byte;
                        word_cnt   <= '0;
                        byte_idx   <= '0;
                        if (i_rx_byte == '0) begin    // Empty program, ack at once
                            o_dump_req <= 1'b1;
                            o_dump_src <= SRC_ACK;
                            state      <= ST_DUMP_BUSY;
                        end else begin
                            state <= ST_LOAD_BYTES;
                        end
                    end
                end
                ST_LOAD_BYTES: begin
                    if (i_rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == '1) begin
                            o_imem_we <= 1'b1;
                            word_cnt  <= word_cnt + 1'b1;
                            if (word_cnt == word_total - 1'b1) begin
                                o_dump_req <= 1'b1;
                                o_dump_src <= SRC_ACK;
                                state      <= ST_DUMP_BUSY;
                            end
                        end
                    end
                end
                ST_READ_ADDR: begin
                    if (i_rx_valid) begin
                        mem_wait_q <= 1'b0;
                        state      <= ST_MEM_WAIT;
                    end
                end
                ST_MEM_WAIT: begin    // Give the data memory two cycles
                    mem_wait_q <= 1'b1;
                    if (mem_wait_q) begin
                        o_dump_req <= 1'b1;
                        o_dump_src <= SRC_MEM;
                        state      <= ST_DUMP_BUSY;
                    end
                end
                ST_DUMP_BUSY: begin
                    if (i_dump_done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_LOAD_BYTES && i_rx_valid) begin
            word_buf <= next_word;
            if (byte_idx == '1) begin
                o_imem_data <= next_word;
                o_imem_addr <= word_cnt[IMEM_ADDR_W-1:0];
            end
        end
        if (state == ST_READ_ADDR && i_rx_valid)
            o_mem_addr <= i_rx_byte[IMEM_ADDR_W-1:0];
    end

endmodule

// ==== verilog/debug_unit_top.sv ====
`timescale 1ns/1ps

module debug_unit_top import debug_pkg::*; #(
    parameter int CLKS_PER_TICK = 326
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_uart_rx,
    input  logic [NUM_REGS*REG_W-1:0] i_registers,
    input  word_t                     i_if_id,
    input  word_t                     i_mem_data,
    output logic                      o_uart_tx,
    output logic                      o_cpu_en,
    output logic                      o_mode_step,
    output logic                      o_imem_we,
    output addr_t                     o_imem_addr,
    output word_t                     o_imem_data,
    output addr_t                     o_mem_addr
);

    logic      tick;
    byte_t     rx_byte;
    logic      rx_valid;
    logic      dump_req;
    dump_src_t dump_src;
    logic      dump_done;

    uart_tx_if tx_link ();

    baud_tick_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_baud (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_receiver u_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_uart_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    uart_transmitter u_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .tx_if   (tx_link),
        .o_tx    (o_uart_tx)
    );

    dump_serializer #(
        .NUM_REGS(NUM_REGS)
    ) u_ser (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_dump_req  (dump_req),
        .i_dump_src  (dump_src),
        .i_registers (i_registers),
        .i_if_id     (i_if_id),
        .i_mem_data  (i_mem_data),
        .tx_if       (tx_link),
        .o_dump_done (dump_done)
    );

    debug_controller u_ctrl (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx_byte   (rx_byte),
        .i_rx_valid  (rx_valid),
        .i_dump_done (dump_done),
        .o_dump_req  (dump_req),
        .o_dump_src  (dump_src),
        .o_cpu_en    (o_cpu_en),
        .o_mode_step (o_mode_step),
        .o_imem_we   (o_imem_we),
        .o_imem_addr (o_imem_addr),
        .o_imem_data (o_imem_data),
        .o_mem_addr  (o_mem_addr)
    );

endmodule

// ==== sim/tb_debug_unit.sv ====
`timescale 1ns/1ps

module tb_debug_unit import debug_pkg::*; ();

    localparam int CLKS_PER_TICK = 4;
    localparam int BIT_CYCLES    = OVERSAMPLE * CLKS_PER_TICK;    // 64 clocks per serial bit
    localparam int REPLY_TIMEOUT = 2000;
    localparam int LOAD_TIMEOUT  = 12000;    // Whole program goes out before the ack
    localparam int PROG_WORDS    = 3;
    localparam addr_t READ_ADDR  = 6'h2D;
    localparam byte_t UNKNOWN_CMD = 8'h5C;

    logic                      i_clk = 1'b0;
    logic                      i_reset;
    logic                      i_uart_rx;
    logic [NUM_REGS*REG_W-1:0] i_registers;
    word_t                     i_if_id;
    word_t                     i_mem_data = '0;
    logic                      o_uart_tx;
    logic                      o_cpu_en;
    logic                      o_mode_step;
    logic                      o_imem_we;
    addr_t                     o_imem_addr;
    word_t                     o_imem_data;
    addr_t                     o_mem_addr;

    word_t reg_words [NUM_REGS];
    word_t mem_model [0:(1 << IMEM_ADDR_W) - 1];
    logic [31:0] rng_state;
    byte_t rx_q[$];
    byte_t exp_q[$];
    addr_t log_addr[$];
    word_t log_data[$];
    int    cpu_en_rises = 0;
    int    cpu_en_high_cycles = 0;
    int    tx_low_cycles = 0;
    int    load_writes_left = 0;    // Words still due while the CPU must stay held
    logic  cpu_en_prev = 1'b0;
    logic  hold_cpu_high = 1'b0;

    debug_unit_top #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_uart_rx   (i_uart_rx),
        .i_registers (i_registers),
        .i_if_id     (i_if_id),
        .i_mem_data  (i_mem_data),
        .o_uart_tx   (o_uart_tx),
        .o_cpu_en    (o_cpu_en),
        .o_mode_step (o_mode_step),
        .o_imem_we   (o_imem_we),
        .o_imem_addr (o_imem_addr),
        .o_imem_data (o_imem_data),
        .o_mem_addr  (o_mem_addr)
    );

    always #10 i_clk = ~i_clk;

    always @(negedge i_clk) begin    // Data memory with one cycle of read latency
        if (!$isunknown(o_mem_addr))
            i_mem_data <= mem_model[o_mem_addr];
    end

    always @(negedge i_clk) begin    // CPU-side monitor and instruction write log
        if (!i_reset) begin
            if (o_imem_we) begin
                log_addr.push_back(o_imem_addr);
                log_data.push_back(o_imem_data);
                if (load_writes_left > 0)
                    load_writes_left--;    // Loading ends with the last word
            end
            if (o_cpu_en && !cpu_en_prev)
                cpu_en_rises++;
            if (o_cpu_en)
                cpu_en_high_cycles++;
            if (!o_uart_tx)
                tx_low_cycles++;
            if (load_writes_left > 0)
                assert (!o_cpu_en) else report_mismatch("o_cpu_en high while loading");
            if (hold_cpu_high)
                assert (o_cpu_en) else report_mismatch("o_cpu_en low in continuous mode");
        end
        cpu_en_prev = o_cpu_en;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("TIMEOUT at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopping on a timeout");
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge i_clk);
    endtask

    task automatic send_serial_byte(input byte_t value);
        byte_t shift;
        shift = value;
        @(negedge i_clk);
        i_uart_rx = 1'b0;    // Start bit
        repeat (BIT_CYCLES) @(negedge i_clk);
        for (int i = 0; i < BYTE_W; i++) begin
            i_uart_rx = shift[0];
            shift = shift >> 1;
            repeat (BIT_CYCLES) @(negedge i_clk);
        end
        i_uart_rx = 1'b1;
        repeat (BIT_CYCLES) @(negedge i_clk);
    endtask

    task automatic receive_serial_bytes(input int count, input int timeout);
        int    waited;
        byte_t value;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            @(negedge i_clk);
            while (o_uart_tx !== 1'b0) begin
                if (waited == timeout)
                    report_timeout($sformatf("no start bit for reply byte %0d", n));
                @(negedge i_clk);
                waited++;
            end
            repeat (BIT_CYCLES / 2) @(negedge i_clk);    // Middle of the start bit
            assert (o_uart_tx == 1'b0)
                else report_mismatch($sformatf("start bit of reply byte %0d not low", n));
            value = '0;
            for (int i = 0; i < BYTE_W; i++) begin
                repeat (BIT_CYCLES) @(negedge i_clk);
                value = {o_uart_tx, value[BYTE_W-1:1]};    // LSB first
            end
            repeat (BIT_CYCLES) @(negedge i_clk);
            assert (o_uart_tx == 1'b1)
                else report_mismatch($sformatf("stop bit of reply byte %0d not high", n));
            rx_q.push_back(value);
        end
    endtask

    task automatic expect_word_bytes(input word_t w);
        word_t rest;
        rest = w;
        for (int i = 0; i < REG_W / BYTE_W; i++) begin
            exp_q.push_back(rest[BYTE_W-1:0]);
            rest = rest >> BYTE_W;
        end
    endtask

    task automatic compare_reply(input string what);
        assert (rx_q.size() == exp_q.size())
            else report_mismatch($sformatf("%s reply has %0d bytes, expected %0d",
                                           what, rx_q.size(), exp_q.size()));
        foreach (exp_q[i])
            assert (rx_q[i] == exp_q[i])
                else report_mismatch($sformatf("%s byte %0d is %02h, expected %02h",
                                               what, i, rx_q[i], exp_q[i]));
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic check_reset_state();
        @(negedge i_clk);
        assert (!o_cpu_en) else report_mismatch("o_cpu_en high after reset");
        assert (!o_imem_we) else report_mismatch("o_imem_we high after reset");
        assert (o_mode_step) else report_mismatch("o_mode_step low after reset");
        assert (o_uart_tx) else report_mismatch("o_uart_tx low after reset");
    endtask

    task automatic check_dump(input byte_t cmd, input int payload, input string what);
        exp_q.push_back(ACK_BYTE);
        fork
            send_serial_byte(cmd);
            receive_serial_bytes(payload + 1, REPLY_TIMEOUT);
        join
        compare_reply(what);
        idle_cycles(BIT_CYCLES);
    endtask

    task automatic check_mem_read();
        expect_word_bytes(mem_model[READ_ADDR]);
        exp_q.push_back(ACK_BYTE);
        fork
            begin
                send_serial_byte(CMD_READ_MEM);
                send_serial_byte(byte_t'(READ_ADDR));
            end
            receive_serial_bytes(5, 2 * REPLY_TIMEOUT);
        join
        assert (o_mem_addr == READ_ADDR)
            else report_mismatch($sformatf("o_mem_addr is %0h, expected %0h",
                                           o_mem_addr, READ_ADDR));
        compare_reply("memory read");
        idle_cycles(BIT_CYCLES);
    endtask

    task automatic check_program_load();
        byte_t prog [PROG_WORDS*4];
        word_t expected;
        foreach (prog[i]) begin
            rng_state = xorshift32(rng_state);
            prog[i] = rng_state[BYTE_W-1:0];
        end
        send_serial_byte(CMD_MODE_CONT);    // Continuous mode, so only the load holds the CPU
        idle_cycles(BIT_CYCLES);
        exp_q.push_back(ACK_BYTE);
        log_addr.delete();
        log_data.delete();
        fork
            begin
                send_serial_byte(CMD_LOAD_PROGRAM);
                load_writes_left = PROG_WORDS;
                send_serial_byte(byte_t'(PROG_WORDS));
                foreach (prog[i])
                    send_serial_byte(prog[i]);
            end
            receive_serial_bytes(1, LOAD_TIMEOUT);
        join
        load_writes_left = 0;
        compare_reply("program load");
        assert (o_cpu_en) else report_mismatch("o_cpu_en still low after loading");
        assert (log_addr.size() == PROG_WORDS)
            else report_mismatch($sformatf("%0d instruction writes, expected %0d",
                                           log_addr.size(), PROG_WORDS));
        foreach (log_addr[i]) begin
            expected = {prog[4*i+3], prog[4*i+2], prog[4*i+1], prog[4*i]};
            assert (log_addr[i] == addr_t'(i))
                else report_mismatch($sformatf("write %0d at address %0d", i, log_addr[i]));
            assert (log_data[i] == expected)
                else report_mismatch($sformatf("write %0d data %08h, expected %08h",
                                               i, log_data[i], expected));
        end
        idle_cycles(BIT_CYCLES);
        send_serial_byte(CMD_MODE_STEP);
        idle_cycles(BIT_CYCLES);
    endtask

    task automatic check_run_control();
        int rises0;
        int high0;
        int tx_low0;
        send_serial_byte(CMD_MODE_CONT);
        idle_cycles(BIT_CYCLES);
        assert (!o_mode_step) else report_mismatch("o_mode_step still high in continuous mode");
        hold_cpu_high = 1'b1;
        idle_cycles(4 * BIT_CYCLES);
        hold_cpu_high = 1'b0;
        send_serial_byte(CMD_MODE_STEP);
        idle_cycles(BIT_CYCLES);
        assert (o_mode_step) else report_mismatch("o_mode_step low after step mode command");
        assert (!o_cpu_en) else report_mismatch("o_cpu_en high in step mode");
        rises0 = cpu_en_rises;
        high0 = cpu_en_high_cycles;
        for (int n = 1; n <= 3; n++) begin
            send_serial_byte(CMD_STEP);
            idle_cycles(BIT_CYCLES);
            assert (cpu_en_rises == rises0 + n)
                else report_mismatch($sformatf("step %0d gave %0d pulses", n,
                                               cpu_en_rises - rises0));
            assert (cpu_en_high_cycles == high0 + n)
                else report_mismatch($sformatf("step %0d pulse not one cycle wide", n));
        end
        rises0 = cpu_en_rises;
        tx_low0 = tx_low_cycles;
        log_addr.delete();
        send_serial_byte(UNKNOWN_CMD);
        idle_cycles(4 * BIT_CYCLES);
        assert (o_mode_step) else report_mismatch("unknown command changed the mode");
        assert (cpu_en_rises == rises0) else report_mismatch("unknown command pulsed o_cpu_en");
        assert (tx_low_cycles == tx_low0)
            else report_mismatch("unknown command sent serial output");
        assert (log_addr.size() == 0)
            else report_mismatch("unknown command wrote instruction memory");
    endtask

    initial begin
        rng_state = 32'd27739;
        i_reset = 1'b1;
        i_uart_rx = 1'b1;    // Idle line
        i_registers = '0;
        foreach (reg_words[i]) begin
            rng_state = xorshift32(rng_state);
            reg_words[i] = rng_state;
            i_registers = {reg_words[i], i_registers[NUM_REGS*REG_W-1:REG_W]};
        end
        rng_state = xorshift32(rng_state);
        i_if_id = rng_state;
        foreach (mem_model[i]) begin
            rng_state = xorshift32(rng_state);
            mem_model[i] = rng_state;
        end
        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;

        check_reset_state();
        foreach (reg_words[i])
            expect_word_bytes(reg_words[i]);
        check_dump(CMD_DUMP_REGS, NUM_REGS * REG_W / BYTE_W, "register dump");
        expect_word_bytes(i_if_id);
        check_dump(CMD_DUMP_IF_ID, REG_W / BYTE_W, "IF/ID dump");
        check_mem_read();
        check_program_load();
        check_run_control();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/debug_pkg.sv
verilog/uart_tx_if.sv
verilog/baud_tick_gen.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/dump_serializer.sv
verilog/debug_controller.sv
verilog/debug_unit_top.sv
sim/tb_debug_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_debug_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
